/* memsys_pkg.sv */
// ================================================
// Memory subsystem package
// Word width, write sizes, accessor and RAM
// request/response structs, controller states
// ================================================

package memsys_pkg;

    // Data word width and byte lanes per word
    localparam int XLEN   = 32;
    localparam int NBYTES = XLEN / 8;

    // Write size as driven by the accessors
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    // One accessor's request levels and payload
    typedef struct packed {
        logic            write;
        logic            read;
        size_e           size;
        logic [31:0]     addr;
        // Payload sits in the low bits
        logic [XLEN-1:0] wdata;
    } acc_req_t;

    // Request towards the data RAM
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [NBYTES-1:0] byte_en;
        logic [31:0]       addr;
        // Already placed on its byte lanes
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    // Answer from the data RAM, valid is a strobe
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    // Access FSM states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RELEASE = 2'd2
    } ctrl_state_e;

endpackage

/* mem_arbiter.sv */
// ================================================
// Accessor arbiter
// Writes beat reads, lowest index wins per kind.
// Latches the winner and tracks its live request.
// ================================================

module mem_arbiter
#(
    parameter int N_ACCESSORS = 2
)(
    input  logic                        clk,
    input  logic                        resetn_i,
    input  memsys_pkg::acc_req_t        acc_req_i [N_ACCESSORS],
    input  logic                        take_i,
    input  logic                        release_i,
    output logic                        sel_valid_o,
    output logic [IDX_W-1:0]            sel_idx_o,
    output memsys_pkg::acc_req_t        sel_req_o,
    output logic                        owner_active_o
);

    localparam int IDX_W = (N_ACCESSORS > 1) ? $clog2(N_ACCESSORS) : 1;

    logic             any_write;
    logic             any_read;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] win_idx;
    logic             win_is_write;

    // Priority scan, descending so that the lowest index ends up winning
    always_comb
    begin
        any_write = 1'b0;
        any_read  = 1'b0;
        wr_idx    = '0;
        rd_idx    = '0;
        for (int i = N_ACCESSORS - 1; i >= 0; i--)
        begin
            if (acc_req_i[i].write)
            begin
                any_write = 1'b1;
                wr_idx    = IDX_W'(i);
            end
            if (acc_req_i[i].read)
            begin
                any_read = 1'b1;
                rd_idx   = IDX_W'(i);
            end
        end
        win_is_write = any_write;
        win_idx      = any_write ? wr_idx : rd_idx;
    end

    // Selection register
    always_ff @(posedge clk)
    begin
        if (!resetn_i)
        begin
            sel_valid_o <= 1'b0;
        end
        else if (release_i)
        begin
            sel_valid_o <= 1'b0;
        end
        else if (take_i && (any_write || any_read))
        begin
            sel_valid_o <= 1'b1;
        end
    end

    // Winner payload, held stable for the controller
    always_ff @(posedge clk)
    begin
        if (take_i && (any_write || any_read))
        begin
            sel_idx_o       <= win_idx;
            sel_req_o       <= acc_req_i[win_idx];
            // Kind is exclusive once latched
            sel_req_o.write <= win_is_write;
            sel_req_o.read  <= !win_is_write;
        end
    end

    // Owner still holding the level of the latched kind
    assign owner_active_o = sel_valid_o &&
                            (sel_req_o.write ? acc_req_i[sel_idx_o].write
                                             : acc_req_i[sel_idx_o].read);

endmodule

/* mem_ctrl.sv */
// ================================================
// Memory access controller
// Runs one RAM access for the selected accessor,
// builds byte lanes and routes done and read data
// ================================================

module mem_ctrl
#(
    parameter int N_ACCESSORS = 2
)(
    input  logic                          clk,
    input  logic                          resetn_i,
    input  logic                          sel_valid_i,
    input  logic [IDX_W-1:0]              sel_idx_i,
    input  memsys_pkg::acc_req_t          sel_req_i,
    input  logic                          owner_active_i,
    output logic                          take_o,
    output logic                          release_o,
    output memsys_pkg::mem_req_t          mem_req_o,
    input  memsys_pkg::mem_rsp_t          mem_rsp_i,
    output logic [N_ACCESSORS-1:0]        acc_done_o,
    output logic [memsys_pkg::XLEN-1:0]   acc_rdata_o [N_ACCESSORS]
);

    localparam int IDX_W = (N_ACCESSORS > 1) ? $clog2(N_ACCESSORS) : 1;

    memsys_pkg::ctrl_state_e          state_q;
    memsys_pkg::ctrl_state_e          state_d;
    logic                             finish;
    logic [memsys_pkg::NBYTES-1:0]    byte_en;
    logic [memsys_pkg::XLEN-1:0]      wdata_lanes;

    // Response counts only while the owner still wants it
    assign finish = mem_rsp_i.valid && owner_active_i;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            memsys_pkg::IDLE:
            begin
                if (sel_valid_i)
                    state_d = memsys_pkg::ACCESS;
            end
            memsys_pkg::ACCESS:
            begin
                // Abandoned request or served, both go through RELEASE
                if (!owner_active_i || finish)
                    state_d = memsys_pkg::RELEASE;
            end
            default:
            begin
                state_d = memsys_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn_i)
            state_q <= memsys_pkg::IDLE;
        else
            state_q <= state_d;
    end

    assign take_o    = (state_q == memsys_pkg::IDLE) && !sel_valid_i;
    assign release_o = (state_q == memsys_pkg::RELEASE);

    // Lane select and data placement
    always_comb
    begin
        case (sel_req_i.size)
            memsys_pkg::SZ_BYTE:
            begin
                byte_en     = 4'b0001 << sel_req_i.addr[1:0];
                wdata_lanes = sel_req_i.wdata << (8 * sel_req_i.addr[1:0]);
            end
            memsys_pkg::SZ_HALF:
            begin
                byte_en     = 4'b0011 << {sel_req_i.addr[1], 1'b0};
                wdata_lanes = sel_req_i.wdata << (16 * sel_req_i.addr[1]);
            end
            default:
            begin
                byte_en     = 4'b1111;
                wdata_lanes = sel_req_i.wdata;
            end
        endcase
    end

    // Valid drops at once when the owner gives up
    assign mem_req_o.valid   = (state_q == memsys_pkg::ACCESS) && owner_active_i;
    assign mem_req_o.write   = sel_req_i.write;
    assign mem_req_o.byte_en = byte_en;
    assign mem_req_o.addr    = sel_req_i.addr;
    assign mem_req_o.wdata   = wdata_lanes;

    // Done pulse lands in the RELEASE cycle
    always_ff @(posedge clk)
    begin
        if (!resetn_i)
        begin
            acc_done_o <= '0;
        end
        else
        begin
            acc_done_o <= '0;
            if (state_q == memsys_pkg::ACCESS && finish)
                acc_done_o[sel_idx_i] <= 1'b1;
        end
    end

    // Read word stays until the owner's next read
    always_ff @(posedge clk)
    begin
        if (state_q == memsys_pkg::ACCESS && finish && sel_req_i.read)
            acc_rdata_o[sel_idx_i] <= mem_rsp_i.rdata;
    end

endmodule

/* data_ram.sv */
// ================================================
// Byte-writable data RAM
// Single port, answers a held request after a
// fixed number of cycles
// ================================================

module data_ram
#(
    parameter int MEM_WORDS   = 1024,
    parameter int RAM_LATENCY = 2
)(
    input  logic                  clk,
    input  logic                  resetn_i,
    input  memsys_pkg::mem_req_t  mem_req_i,
    output memsys_pkg::mem_rsp_t  mem_rsp_o
);

    localparam int AW    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(RAM_LATENCY + 1);

    logic [memsys_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [CNT_W-1:0]            cnt_q;
    logic                        rsp_valid_q;
    logic [memsys_pkg::XLEN-1:0] rdata_q;
    logic [AW-1:0]               word_idx;
    logic                        fire;

    // Word bits of the byte address
    assign word_idx = mem_req_i.addr[AW+1:2];

    // Last counted cycle, the answer shows up on the next one
    assign fire = mem_req_i.valid && (cnt_q == CNT_W'(RAM_LATENCY - 1));

    // Latency counter, holds at RAM_LATENCY until valid falls
    always_ff @(posedge clk)
    begin
        if (!resetn_i)
        begin
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
        end
        else if (!mem_req_i.valid)
        begin
            // Pending access dropped
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            if (cnt_q < CNT_W'(RAM_LATENCY))
                cnt_q <= cnt_q + 1'b1;
            rsp_valid_q <= fire;
        end
    end

    // Array access, committed together with the strobe
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            if (mem_req_i.write)
            begin
                for (int b = 0; b < memsys_pkg::NBYTES; b++)
                begin
                    if (mem_req_i.byte_en[b])
                        mem[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
                end
            end
            rdata_q <= mem[word_idx];
        end
    end

    assign mem_rsp_o.valid = rsp_valid_q;
    assign mem_rsp_o.rdata = rdata_q;

endmodule

/* memsys_top.sv */
// ================================================
// Memory subsystem top
// Shared single-port RAM behind an arbiter and
// an access controller
// ================================================

module memsys_top
#(
    parameter int N_ACCESSORS = 2,
    parameter int MEM_WORDS   = 1024,
    parameter int RAM_LATENCY = 2
)(
    input  logic                          clk,
    input  logic                          resetn_i,
    input  memsys_pkg::acc_req_t          acc_req_i [N_ACCESSORS],
    output logic [N_ACCESSORS-1:0]        acc_done_o,
    output logic [memsys_pkg::XLEN-1:0]   acc_rdata_o [N_ACCESSORS]
);

    localparam int IDX_W = (N_ACCESSORS > 1) ? $clog2(N_ACCESSORS) : 1;

    logic                  sel_valid;
    logic [IDX_W-1:0]      sel_idx;
    memsys_pkg::acc_req_t  sel_req;
    logic                  owner_active;
    logic                  take;
    logic                  release_sel;
    memsys_pkg::mem_req_t  mem_req;
    memsys_pkg::mem_rsp_t  mem_rsp;

    mem_arbiter #(
        .N_ACCESSORS (N_ACCESSORS)
    ) u_mem_arbiter (
        .clk            (clk),
        .resetn_i       (resetn_i),
        .acc_req_i      (acc_req_i),
        .take_i         (take),
        .release_i      (release_sel),
        .sel_valid_o    (sel_valid),
        .sel_idx_o      (sel_idx),
        .sel_req_o      (sel_req),
        .owner_active_o (owner_active)
    );

    mem_ctrl #(
        .N_ACCESSORS (N_ACCESSORS)
    ) u_mem_ctrl (
        .clk            (clk),
        .resetn_i       (resetn_i),
        .sel_valid_i    (sel_valid),
        .sel_idx_i      (sel_idx),
        .sel_req_i      (sel_req),
        .owner_active_i (owner_active),
        .take_o         (take),
        .release_o      (release_sel),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .acc_done_o     (acc_done_o),
        .acc_rdata_o    (acc_rdata_o)
    );

    data_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_data_ram (
        .clk       (clk),
        .resetn_i  (resetn_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

/* tb_util.svh */
// ================================================
// Testbench helpers
// LFSR random bits, value check and done wait
// ================================================

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Galois taps for a maximal length 32-bit sequence
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
        return (state >> 1) ^ LFSR_TAPS;
    return state >> 1;
endfunction

// One LFSR step per bit taken, first bit ends up as MSB
function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
endfunction

task automatic fail_now(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Stopped at first failure");
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected)
        fail_now($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                           $time, name, got, expected));
endtask

// Sampled on the falling edge, away from the register updates
task automatic wait_done(input int idx, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (acc_done[idx] !== 1'b1)
    begin
        for (int i = 0; i < N_ACC; i++)
        begin
            if (i != idx && acc_done[i])
                fail_now($sformatf("Done for accessor %0d while accessor %0d was expected",
                                   i, idx));
        end
        if (cycles >= limit)
            fail_now($sformatf("No done for accessor %0d within %0d cycles", idx, limit));
        cycles++;
        @(negedge clk);
    end
endtask

`endif

/* tb_memsys.sv */
// ================================================
// Memory subsystem testbench
// Random accesses by two accessors, checked
// against a byte-level reference model
// ================================================

module tb_memsys;

    localparam int N_ACC     = 2;
    localparam int MEM_WORDS = 64;
    localparam int LATENCY   = 2;
    localparam int DONE_WAIT = 20;

    logic                         clk;
    logic                         resetn;
    memsys_pkg::acc_req_t         acc_req [N_ACC];
    logic [N_ACC-1:0]             acc_done;
    logic [memsys_pkg::XLEN-1:0]  acc_rdata [N_ACC];
    logic [31:0]                  lfsr_state;
    // One entry per RAM byte
    logic [7:0]                   model_mem [MEM_WORDS*4];
    // Last word each accessor read and whether it has read at all
    logic [31:0]                  last_rdata [N_ACC];
    logic                         rdata_seen [N_ACC];

    `include "tb_util.svh"

    memsys_top #(
        .N_ACCESSORS (N_ACC),
        .MEM_WORDS   (MEM_WORDS),
        .RAM_LATENCY (LATENCY)
    ) u_memsys_top (
        .clk         (clk),
        .resetn_i    (resetn),
        .acc_req_i   (acc_req),
        .acc_done_o  (acc_done),
        .acc_rdata_o (acc_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word index wraps modulo the RAM size
    function automatic int byte_index(input logic [31:0] addr, input int lane);
        return (int'(addr >> 2) % MEM_WORDS) * 4 + lane;
    endfunction

    function automatic void model_write(input logic [31:0] addr,
                                        input memsys_pkg::size_e size,
                                        input logic [31:0] wdata);
        int lane;
        case (size)
            memsys_pkg::SZ_BYTE:
            begin
                model_mem[byte_index(addr, int'(addr[1:0]))] = wdata[7:0];
            end
            memsys_pkg::SZ_HALF:
            begin
                lane = addr[1] ? 2 : 0;
                model_mem[byte_index(addr, lane)]     = wdata[7:0];
                model_mem[byte_index(addr, lane + 1)] = wdata[15:8];
            end
            default:
            begin
                for (int b = 0; b < 4; b++)
                    model_mem[byte_index(addr, b)] = wdata[8*b +: 8];
            end
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {model_mem[byte_index(addr, 3)], model_mem[byte_index(addr, 2)],
                model_mem[byte_index(addr, 1)], model_mem[byte_index(addr, 0)]};
    endfunction

    task automatic post_request(input int idx, input logic is_write,
                                input memsys_pkg::size_e size,
                                input logic [31:0] addr, input logic [31:0] wdata);
        memsys_pkg::acc_req_t req;
        req.write = is_write;
        req.read  = !is_write;
        req.size  = size;
        req.addr  = addr;
        req.wdata = wdata;
        acc_req[idx] <= req;
    endtask

    // Wait for done, check it, drop the request, expect a one-cycle pulse
    task automatic finish_request(input int idx, input logic is_write,
                                  input memsys_pkg::size_e size,
                                  input logic [31:0] addr, input logic [31:0] wdata);
        wait_done(idx, DONE_WAIT);
        check_value("acc_done_o", 32'(acc_done), 32'(1) << idx);
        if (is_write)
        begin
            model_write(addr, size, wdata);
        end
        else
        begin
            last_rdata[idx] = model_word(addr);
            rdata_seen[idx] = 1'b1;
        end
        // Each read word stays on its own output until that accessor reads again
        for (int i = 0; i < N_ACC; i++)
        begin
            if (rdata_seen[i])
                check_value($sformatf("acc_rdata_o[%0d]", i), acc_rdata[i], last_rdata[i]);
        end
        @(posedge clk);
        acc_req[idx] <= '0;
        @(negedge clk);
        check_value("acc_done_o", 32'(acc_done), 32'd0);
    endtask

    task automatic run_access(input int idx, input logic is_write,
                              input memsys_pkg::size_e size,
                              input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        post_request(idx, is_write, size, addr, wdata);
        finish_request(idx, is_write, size, addr, wdata);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk);
            check_value("acc_done_o", 32'(acc_done), 32'd0);
        end
    endtask

    // Both raise in one cycle where a write beats a read and otherwise accessor 0 goes first
    task automatic race_pair(input logic w0, input logic w1);
        logic [31:0] addr0;
        logic [31:0] addr1;
        logic [31:0] data0;
        logic [31:0] data1;
        addr0 = rand_bits(32) & 32'hffff_fffc;
        addr1 = rand_bits(32) & 32'hffff_fffc;
        data0 = rand_bits(32);
        data1 = rand_bits(32);
        @(posedge clk);
        post_request(0, w0, memsys_pkg::SZ_WORD, addr0, data0);
        post_request(1, w1, memsys_pkg::SZ_WORD, addr1, data1);
        if (!w0 && w1)
        begin
            finish_request(1, w1, memsys_pkg::SZ_WORD, addr1, data1);
            finish_request(0, w0, memsys_pkg::SZ_WORD, addr0, data0);
        end
        else
        begin
            finish_request(0, w0, memsys_pkg::SZ_WORD, addr0, data0);
            finish_request(1, w1, memsys_pkg::SZ_WORD, addr1, data1);
        end
    endtask

    // Read level held for one cycle only
    task automatic abandon_read(input int idx);
        logic [31:0] addr;
        addr = rand_bits(32) & 32'hffff_fffc;
        @(posedge clk);
        post_request(idx, 1'b0, memsys_pkg::SZ_WORD, addr, 32'd0);
        @(posedge clk);
        acc_req[idx] <= '0;
        expect_quiet(DONE_WAIT);
    endtask

    initial
    begin
        logic [31:0]       addr;
        logic [31:0]       data;
        int                idx;
        memsys_pkg::size_e size;

        lfsr_state = 32'h9a40_1f47;
        resetn <= 1'b0;
        for (int i = 0; i < N_ACC; i++)
        begin
            acc_req[i]    <= '0;
            rdata_seen[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        expect_quiet(10);

        // Every word written once by alternating accessors
        for (int w = 0; w < MEM_WORDS; w++)
            run_access(w % N_ACC, 1'b1, memsys_pkg::SZ_WORD, 32'(w * 4), rand_bits(32));

        // Word writes read back by either accessor
        for (int n = 0; n < 40; n++)
        begin
            idx  = int'(rand_bits(1));
            addr = rand_bits(32) & 32'hffff_fffc;
            data = rand_bits(32);
            run_access(idx, 1'b1, memsys_pkg::SZ_WORD, addr, data);
            run_access(int'(rand_bits(1)), 1'b0, memsys_pkg::SZ_WORD, addr, 32'd0);
            addr = rand_bits(32) & 32'hffff_fffc;
            run_access(int'(rand_bits(1)), 1'b0, memsys_pkg::SZ_WORD, addr, 32'd0);
        end

        // Byte and half writes each followed by a full word read
        for (int n = 0; n < 60; n++)
        begin
            idx  = int'(rand_bits(1));
            size = rand_bits(1) ? memsys_pkg::SZ_HALF : memsys_pkg::SZ_BYTE;
            addr = rand_bits(32);
            if (size == memsys_pkg::SZ_HALF)
                addr[0] = 1'b0;
            data = rand_bits(32);
            run_access(idx, 1'b1, size, addr, data);
            run_access(int'(rand_bits(1)), 1'b0, memsys_pkg::SZ_WORD,
                       addr & 32'hffff_fffc, 32'd0);
        end

        for (int n = 0; n < 8; n++)
            race_pair(n[1], n[0]);

        abandon_read(0);
        run_access(1, 1'b0, memsys_pkg::SZ_WORD, rand_bits(32) & 32'hffff_fffc, 32'd0);
        abandon_read(1);
        run_access(0, 1'b0, memsys_pkg::SZ_WORD, rand_bits(32) & 32'hffff_fffc, 32'd0);

        // All requests dropped by now
        expect_quiet(20);
        $display("Everything OK");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
memsys_pkg.sv
mem_arbiter.sv
mem_ctrl.sv
data_ram.sv
memsys_top.sv
tb_memsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_memsys -f build.f

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/Vtb_memsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
